//--- rtl/fp_compare_pkg.sv
package fp_compare_pkg;

    // IEEE 754 single precision layout
    localparam int DATA_WIDTH = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int MANT_WIDTH = 23;

    typedef logic [DATA_WIDTH-1:0] fp_word_t;

    // Canonical quiet NaN, also the idle value of the min/max result
    localparam fp_word_t QNAN = {1'b0, {EXP_WIDTH{1'b1}}, 1'b1, {(MANT_WIDTH-1){1'b0}}};

    // The eight operations fill the 3-bit code exactly
    typedef enum logic [2:0] {
        FEQ  = 3'd0,
        FNE  = 3'd1,
        FLT  = 3'd2,
        FLE  = 3'd3,
        FGT  = 3'd4,
        FGE  = 3'd5,
        FMIN = 3'd6,
        FMAX = 3'd7
    } fp_op_e;

    // Relation of operand a to operand b
    typedef enum logic [2:0] {
        REL_LT       = 3'd0,
        REL_EQ       = 3'd1,
        REL_GT       = 3'd2,
        REL_A_NAN    = 3'd3,
        REL_B_NAN    = 3'd4,
        REL_BOTH_NAN = 3'd5
    } fp_rel_e;

    // Per-operand fields after stage 1
    typedef struct packed {
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exp;
        logic [MANT_WIDTH:0]   mant;    // Hidden bit on top
        logic                  is_nan;
        logic                  is_zero;
    } fp_class_t;

endpackage

//--- rtl/fp_stage_if.sv
`timescale 1ns/1ps

// Stage 1 to stage 2: raw words plus the classified fields
interface fp_class_if;
    logic                      valid;
    fp_compare_pkg::fp_op_e    op;
    fp_compare_pkg::fp_word_t  a;
    fp_compare_pkg::fp_word_t  b;
    fp_compare_pkg::fp_class_t a_class;
    fp_compare_pkg::fp_class_t b_class;

    modport src (
        output valid,
        output op,
        output a,
        output b,
        output a_class,
        output b_class
    );

    modport dst (
        input valid,
        input op,
        input a,
        input b,
        input a_class,
        input b_class
    );
endinterface

// Stage 2 to stage 3: raw words kept for min/max, plus the relation
interface fp_order_if;
    logic                     valid;
    fp_compare_pkg::fp_op_e   op;
    fp_compare_pkg::fp_word_t a;
    fp_compare_pkg::fp_word_t b;
    fp_compare_pkg::fp_rel_e  rel;

    modport src (output valid, output op, output a, output b, output rel);

    modport dst (input valid, input op, input a, input b, input rel);
endinterface

//--- rtl/fp_classify.sv
`timescale 1ns/1ps

module fp_classify (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  fp_compare_pkg::fp_op_e   in_op,
    input  fp_compare_pkg::fp_word_t a,
    input  fp_compare_pkg::fp_word_t b,
    fp_class_if.src                  cls
);

    localparam int EW = fp_compare_pkg::EXP_WIDTH;
    localparam int MW = fp_compare_pkg::MANT_WIDTH;

    fp_compare_pkg::fp_class_t a_class_d;
    fp_compare_pkg::fp_class_t b_class_d;

    // Split one word into sign, exponent and padded mantissa, and flag specials
    function automatic fp_compare_pkg::fp_class_t classify(input fp_compare_pkg::fp_word_t w);
        fp_compare_pkg::fp_class_t c;
        logic [EW-1:0] e;
        logic [MW-1:0] m;
        e         = w[EW+MW-1:MW];
        m         = w[MW-1:0];
        c.sign    = w[EW+MW];
        c.exp     = e;
        c.mant    = {(e != '0), m};     // Denormals and zero get no hidden one
        c.is_nan  = (e == '1) && (m != '0);
        c.is_zero = (e == '0) && (m == '0);
        return c;
    endfunction

    always_comb begin
        a_class_d = classify(a);
        b_class_d = classify(b);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cls.valid <= 1'b0;
        end else begin
            cls.valid <= in_valid;
        end
    end

    // Payload only moves on a valid input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            cls.op      <= in_op;
            cls.a       <= a;
            cls.b       <= b;
            cls.a_class <= a_class_d;
            cls.b_class <= b_class_d;
        end
    end

    a_op_known: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !$isunknown(in_op))
        else $error("fp_classify: unknown opcode on a valid input");

endmodule

//--- rtl/fp_order_compare.sv
`timescale 1ns/1ps

module fp_order_compare (
    input  logic    clk,
    input  logic    rst,
    fp_class_if.dst cls,
    fp_order_if.src ord
);

    localparam int MAG_WIDTH = fp_compare_pkg::EXP_WIDTH + fp_compare_pkg::MANT_WIDTH + 1;

    fp_compare_pkg::fp_rel_e rel_d;
    logic [MAG_WIDTH-1:0]    mag_a;
    logic [MAG_WIDTH-1:0]    mag_b;
    logic                    a_bigger;

    // Exponent above mantissa, so one unsigned compare orders the magnitudes
    assign mag_a    = {cls.a_class.exp, cls.a_class.mant};
    assign mag_b    = {cls.b_class.exp, cls.b_class.mant};
    assign a_bigger = mag_a > mag_b;

    always_comb begin
        if (cls.a_class.is_nan && cls.b_class.is_nan) begin
            rel_d = fp_compare_pkg::REL_BOTH_NAN;
        end else if (cls.a_class.is_nan) begin
            rel_d = fp_compare_pkg::REL_A_NAN;
        end else if (cls.b_class.is_nan) begin
            rel_d = fp_compare_pkg::REL_B_NAN;
        end else if (cls.a_class.is_zero && cls.b_class.is_zero) begin
            rel_d = fp_compare_pkg::REL_EQ;     // +0 equals -0
        end else if (cls.a_class.sign != cls.b_class.sign) begin
            // Positive side wins
            rel_d = cls.a_class.sign ? fp_compare_pkg::REL_LT : fp_compare_pkg::REL_GT;
        end else if (mag_a == mag_b) begin
            rel_d = fp_compare_pkg::REL_EQ;
        end else if (a_bigger ^ cls.a_class.sign) begin
            rel_d = fp_compare_pkg::REL_GT;     // Larger magnitude loses when negative
        end else begin
            rel_d = fp_compare_pkg::REL_LT;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ord.valid <= 1'b0;
        end else begin
            ord.valid <= cls.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cls.valid) begin
            ord.op  <= cls.op;
            ord.a   <= cls.a;
            ord.b   <= cls.b;
            ord.rel <= rel_d;
        end
    end

    // Identical non-NaN words must come out equal
    a_same_word_equal: assert property (@(posedge clk) disable iff (rst)
        cls.valid && !cls.a_class.is_nan && (cls.a == cls.b)
        |=> ord.rel == fp_compare_pkg::REL_EQ)
        else $error("fp_order_compare: identical operands not related as equal");

endmodule

//--- rtl/fp_result_select.sv
`timescale 1ns/1ps

module fp_result_select (
    input  logic                      clk,
    input  logic                      rst,
    fp_order_if.dst                   ord,
    output logic                      out_valid,
    output logic                      result_bool,
    output fp_compare_pkg::fp_word_t  result_fp
);

    localparam int SIGN_BIT = fp_compare_pkg::DATA_WIDTH - 1;
    localparam int MW       = fp_compare_pkg::MANT_WIDTH;

    logic                     bool_d;
    fp_compare_pkg::fp_word_t fp_d;
    logic                     want_min;
    logic                     eq_sign;
    logic                     a_nan;
    logic                     b_nan;
    logic                     res_nan;

    assign want_min = (ord.op == fp_compare_pkg::FMIN);

    // Equal operands differ at most in the sign of a zero
    // OR keeps -0 for min, AND keeps +0 for max
    assign eq_sign = want_min ? (ord.a[SIGN_BIT] | ord.b[SIGN_BIT])
                              : (ord.a[SIGN_BIT] & ord.b[SIGN_BIT]);

    // NaN tests straight on the raw words
    assign a_nan   = (ord.a[SIGN_BIT-1:MW] == '1) && (ord.a[MW-1:0] != '0);
    assign b_nan   = (ord.b[SIGN_BIT-1:MW] == '1) && (ord.b[MW-1:0] != '0);
    assign res_nan = (result_fp[SIGN_BIT-1:MW] == '1) && (result_fp[MW-1:0] != '0);

    always_comb begin
        bool_d = 1'b0;
        fp_d   = fp_compare_pkg::QNAN;
        case (ord.op)
            fp_compare_pkg::FEQ: bool_d = (ord.rel == fp_compare_pkg::REL_EQ);
            fp_compare_pkg::FNE: bool_d = (ord.rel != fp_compare_pkg::REL_EQ);  // NaN lands here
            fp_compare_pkg::FLT: bool_d = (ord.rel == fp_compare_pkg::REL_LT);
            fp_compare_pkg::FLE: begin
                bool_d = (ord.rel == fp_compare_pkg::REL_LT) ||
                         (ord.rel == fp_compare_pkg::REL_EQ);
            end
            fp_compare_pkg::FGT: bool_d = (ord.rel == fp_compare_pkg::REL_GT);
            fp_compare_pkg::FGE: begin
                bool_d = (ord.rel == fp_compare_pkg::REL_GT) ||
                         (ord.rel == fp_compare_pkg::REL_EQ);
            end
            fp_compare_pkg::FMIN, fp_compare_pkg::FMAX: begin
                case (ord.rel)
                    fp_compare_pkg::REL_A_NAN: fp_d = ord.b;   // NaN yields the other operand
                    fp_compare_pkg::REL_B_NAN: fp_d = ord.a;
                    fp_compare_pkg::REL_LT:    fp_d = want_min ? ord.a : ord.b;
                    fp_compare_pkg::REL_GT:    fp_d = want_min ? ord.b : ord.a;
                    fp_compare_pkg::REL_EQ:    fp_d = {eq_sign, ord.a[SIGN_BIT-1:0]};
                    default:                   fp_d = fp_compare_pkg::QNAN;
                endcase
            end
        endcase
    end

    // Results hold between valid outputs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid   <= 1'b0;
            result_bool <= 1'b0;
            result_fp   <= fp_compare_pkg::QNAN;
        end else begin
            out_valid <= ord.valid;
            if (ord.valid) begin
                result_bool <= bool_d;
                result_fp   <= fp_d;
            end
        end
    end

    // Min/max gives a NaN only for a NaN pair
    a_minmax_nan_pair_only: assert property (@(posedge clk) disable iff (rst)
        ord.valid && (ord.op inside {fp_compare_pkg::FMIN, fp_compare_pkg::FMAX})
        && !(a_nan && b_nan)
        |=> !result_bool && !res_nan)
        else $error("fp_result_select: min/max gave a flag or a NaN from a non-NaN pair");

endmodule

//--- rtl/fp_compare_top.sv
`timescale 1ns/1ps

module fp_compare_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  fp_compare_pkg::fp_op_e    in_op,
    input  fp_compare_pkg::fp_word_t  a,
    input  fp_compare_pkg::fp_word_t  b,
    output logic                      out_valid,
    output logic                      result_bool,
    output fp_compare_pkg::fp_word_t  result_fp
);

    // Stage links
    fp_class_if cls_if ();
    fp_order_if ord_if ();

    // Stage 1, field split and special flags
    fp_classify fp_classify_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_op    (in_op),
        .a        (a),
        .b        (b),
        .cls      (cls_if.src)
    );

    // Stage 2, numeric relation
    fp_order_compare fp_order_compare_i (
        .clk (clk),
        .rst (rst),
        .cls (cls_if.dst),
        .ord (ord_if.src)
    );

    // Stage 3, boolean and min/max
    fp_result_select fp_result_select_i (
        .clk         (clk),
        .rst         (rst),
        .ord         (ord_if.dst),
        .out_valid   (out_valid),
        .result_bool (result_bool),
        .result_fp   (result_fp)
    );

endmodule

//--- verification/fp_compare_tb.sv
`timescale 1ns/1ps

module fp_compare_tb;

    localparam logic [31:0] CANON_QNAN  = 32'h7fc0_0000;
    localparam int          LATENCY     = 3;
    localparam int          DRAIN_LIMIT = 50;
    localparam int          STIM_LIMIT  = 1000;
    localparam string       VEC_FILE    = "verification/fp_compare_vectors.txt";

    typedef struct packed {
        logic        exp_bool;
        logic [31:0] exp_fp;
        logic [31:0] stamp;     // Edge on which the vector was driven
        logic [31:0] index;
    } expect_t;

    logic                     clk;
    logic                     rst;
    logic                     in_valid;
    fp_compare_pkg::fp_op_e   in_op;
    fp_compare_pkg::fp_word_t a;
    fp_compare_pkg::fp_word_t b;
    logic                     out_valid;
    logic                     result_bool;
    fp_compare_pkg::fp_word_t result_fp;

    logic [2:0]               vec_op[$];
    fp_compare_pkg::fp_word_t vec_a[$];
    fp_compare_pkg::fp_word_t vec_b[$];
    logic                     vec_bool[$];
    fp_compare_pkg::fp_word_t vec_fp[$];
    expect_t                  expect_q[$];

    int edge_count = 0;
    int checks     = 0;
    int errors     = 0;
    int results    = 0;

    fp_compare_top fp_compare_top_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .a           (a),
        .b           (b),
        .out_valid   (out_valid),
        .result_bool (result_bool),
        .result_fp   (result_fp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) edge_count <= edge_count + 1;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    // Lines starting with # are column notes
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_bool;
        logic [31:0] f_fp;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the vector file %s", VEC_FILE);
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_bool, f_fp);
                if (n == 5) begin
                    vec_op.push_back(f_op[2:0]);
                    vec_a.push_back(f_a);
                    vec_b.push_back(f_b);
                    vec_bool.push_back(f_bool[0]);
                    vec_fp.push_back(f_fp);
                end
            end
        end
        $fclose(fd);
    endtask

    // Results in input order, each exactly three edges after it was driven
    always @(negedge clk) begin
        expect_t e;
        if (!rst && out_valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("A result arrived at %0t with no operation in flight", $time);
            end else begin
                e = expect_q.pop_front();
                results++;
                check_value($sformatf("vector %0d latency", e.index),
                            32'(edge_count - 1 - int'(e.stamp)), 32'(LATENCY));
                check_value($sformatf("vector %0d result_bool", e.index),
                            {31'b0, result_bool}, {31'b0, e.exp_bool});
                check_value($sformatf("vector %0d result_fp", e.index), result_fp, e.exp_fp);
            end
        end
    end

    initial begin
        int      idx;
        int      cycles;
        int      waited;
        expect_t pending;
        void'($urandom(89));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = fp_compare_pkg::FEQ;
        a        = '0;
        b        = '0;
        load_vectors();
        if (vec_op.size() == 0) begin
            errors++;
            $display("No vectors were read");
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Idle outputs right after reset
        @(negedge clk);
        check_value("reset out_valid", {31'b0, out_valid}, 32'h0);
        check_value("reset result_bool", {31'b0, result_bool}, 32'h0);
        check_value("reset result_fp", result_fp, CANON_QNAN);

        idx    = 0;
        cycles = 0;
        while (idx < vec_op.size() && cycles < STIM_LIMIT) begin
            @(posedge clk);
            cycles++;
            // First vectors go back to back to fill the pipeline
            if (idx >= 6 && ($urandom % 4) == 0) begin
                in_valid <= 1'b0;
            end else begin
                in_valid <= 1'b1;
                in_op    <= fp_compare_pkg::fp_op_e'(vec_op[idx]);
                a        <= vec_a[idx];
                b        <= vec_b[idx];
                pending.exp_bool = vec_bool[idx];
                pending.exp_fp   = vec_fp[idx];
                pending.stamp    = 32'(edge_count);
                pending.index    = 32'(idx);
                expect_q.push_back(pending);
                idx++;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        waited = 0;
        while (expect_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            errors++;
            $display("Timed out with %0d results still missing", expect_q.size());
        end else begin
            repeat (LATENCY + 1) @(posedge clk);   // Room for a stray extra result
        end
        check_value("result count", 32'(results), 32'(vec_op.size()));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- fp_compare.f
rtl/fp_compare_pkg.sv
rtl/fp_stage_if.sv
rtl/fp_classify.sv
rtl/fp_order_compare.sv
rtl/fp_result_select.sv
rtl/fp_compare_top.sv
verification/fp_compare_tb.sv

//--- Makefile
# Verilator build and run for the floating-point compare unit

VERILATOR ?= verilator
TOP       ?= fp_compare_tb
FILELIST  ?= fp_compare.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/fp_compare_vectors.txt
# op a b expected_bool expected_value, all hex
# op 0 FEQ 1 FNE 2 FLT 3 FLE 4 FGT 5 FGE 6 FMIN 7 FMAX
0 3f800000 bf800000 0 7fc00000
1 3f800000 bf800000 1 7fc00000
2 bf800000 3f800000 1 7fc00000
3 3fc00000 3fa00000 0 7fc00000
4 3fc00000 3fa00000 1 7fc00000
5 c0000000 bf800000 0 7fc00000
2 c0000000 bf800000 1 7fc00000
5 3f800000 3f800000 1 7fc00000
0 00000000 80000000 1 7fc00000
3 80000000 00000000 1 7fc00000
4 7f800000 42c80000 1 7fc00000
2 ff800000 7f800000 1 7fc00000
3 ff800000 c0000000 1 7fc00000
0 7fc00000 7fc00000 0 7fc00000
1 7f800001 3f800000 1 7fc00000
5 3f800000 ffc00000 0 7fc00000
4 00000001 00000000 1 7fc00000
6 40400000 3f800000 0 3f800000
7 c0000000 bf800000 0 bf800000
6 7fc00000 40000000 0 40000000
7 bf800000 7f800001 0 bf800000
6 7f800001 ffc00000 0 7fc00000
6 00000000 80000000 0 80000000
7 80000000 00000000 0 00000000
7 ff800000 3f800000 0 3f800000
